//--- design/alu_pkg.sv
package alu_pkg;

  ////////////////////////////// widths
  localparam int xlen    = 32; // core is fixed at rv32
  localparam int shamt_w = 5;  // log2(xlen)

  typedef logic [xlen-1:0]    word_t;       // operands and results
  typedef logic [xlen:0]      adder_word_t; // ext bit + word, msb is sign of diff
  typedef logic [shamt_w-1:0] shamt_t;      // shift amount, from op2[4:0]

  ////////////////////////////// operation codes
  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_xor,
    op_or,
    op_and,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_mvop2,   // lui and swap
    op_max,
    op_min,
    op_maxu,
    op_minu,
    op_cmp_eq,  // branch compares below
    op_cmp_ne,
    op_cmp_lt,
    op_cmp_gt,
    op_cmp_ltu,
    op_cmp_gtu
  } alu_op_t;

  // which source drives res
  typedef enum logic [2:0] {
    sel_none, sel_adder, sel_logic, sel_shift, sel_slt, sel_op2, sel_maxmin
  } res_sel_t;

  typedef enum logic [1:0] {
    lk_xor, lk_or, lk_and
  } logic_kind_t;

  // compare flavour, maxsel_* only pick an operand, no cmp_taken
  typedef enum logic [2:0] {
    ck_none, ck_eq, ck_ne, ck_lt, ck_gt, ck_maxsel_max, ck_maxsel_min
  } cmp_kind_t;

endpackage

//--- design/alu_decode.sv
module alu_decode (
  input  logic                 req,
  input  alu_pkg::alu_op_t     op,
  output logic                 shift_en,
  output logic                 shift_right,
  output logic                 shift_arith,
  output logic                 add_en,
  output logic                 sub_en,
  output logic                 op_unsigned,
  output alu_pkg::res_sel_t    res_sel,
  output alu_pkg::logic_kind_t logic_kind,
  output alu_pkg::cmp_kind_t   cmp_kind
);
  import alu_pkg::*;

  always_comb begin
    // everything idle unless a request is present
    shift_en    = 1'b0;
    shift_right = 1'b0;
    shift_arith = 1'b0;
    add_en      = 1'b0;
    sub_en      = 1'b0;
    op_unsigned = 1'b0;
    res_sel     = sel_none;
    logic_kind  = lk_xor;
    cmp_kind    = ck_none;
    if (req) begin
      case (op)
        op_add:   begin add_en = 1'b1; res_sel = sel_adder; end
        op_sub:   begin sub_en = 1'b1; res_sel = sel_adder; end
        op_xor:   begin res_sel = sel_logic; logic_kind = lk_xor; end
        op_or:    begin res_sel = sel_logic; logic_kind = lk_or;  end
        op_and:   begin res_sel = sel_logic; logic_kind = lk_and; end
        //////////////////////////////
        // shifts, right ones reuse the left shifter
        op_sll:   begin shift_en = 1'b1; res_sel = sel_shift; end
        op_srl: begin
          shift_en    = 1'b1;
          shift_right = 1'b1;
          res_sel     = sel_shift;
        end
        op_sra: begin
          shift_en    = 1'b1;
          shift_right = 1'b1;
          shift_arith = 1'b1; // sign fill
          res_sel     = sel_shift;
        end
        //////////////////////////////
        // adder used as comparator
        op_slt:   begin sub_en = 1'b1; res_sel = sel_slt; end
        op_sltu:  begin sub_en = 1'b1; op_unsigned = 1'b1; res_sel = sel_slt; end
        op_mvop2: res_sel = sel_op2; // op2 passes straight through
        op_max:   begin sub_en = 1'b1; res_sel = sel_maxmin; cmp_kind = ck_maxsel_max; end
        op_min:   begin sub_en = 1'b1; res_sel = sel_maxmin; cmp_kind = ck_maxsel_min; end
        op_maxu: begin
          sub_en = 1'b1; op_unsigned = 1'b1;
          res_sel = sel_maxmin; cmp_kind = ck_maxsel_max;
        end
        op_minu: begin
          sub_en = 1'b1; op_unsigned = 1'b1;
          res_sel = sel_maxmin; cmp_kind = ck_maxsel_min;
        end
        // branch compares, res stays zero
        op_cmp_eq:  begin sub_en = 1'b1; logic_kind = lk_xor; cmp_kind = ck_eq; end
        op_cmp_ne:  begin sub_en = 1'b1; logic_kind = lk_xor; cmp_kind = ck_ne; end
        op_cmp_lt:  begin sub_en = 1'b1; cmp_kind = ck_lt; end
        op_cmp_gt:  begin sub_en = 1'b1; cmp_kind = ck_gt; end
        op_cmp_ltu: begin sub_en = 1'b1; op_unsigned = 1'b1; cmp_kind = ck_lt; end
        op_cmp_gtu: begin sub_en = 1'b1; op_unsigned = 1'b1; cmp_kind = ck_gt; end
        default:  res_sel = sel_none; // unused codes do nothing
      endcase
    end
  end

endmodule

//--- design/alu_shifter.sv
module alu_shifter (
  input  logic            shift_en,
  input  logic            shift_right,
  input  logic            shift_arith,
  input  alu_pkg::word_t  op1,
  input  alu_pkg::shamt_t shamt,
  output alu_pkg::word_t  shift_res
);
  import alu_pkg::*;

  word_t  shl_in;   // operand after gating and optional reversal
  word_t  shl_out;  // raw left shift
  word_t  srl_res;
  word_t  sra_res;
  word_t  eff_mask; // ones where srl kept real bits
  shamt_t amt;

  // mirror a word, msb <-> lsb
  function automatic word_t bit_rev(input word_t v);
    word_t r;
    for (int i = 0; i < xlen; i++) begin
      r[i] = v[xlen-1-i];
    end
    return r;
  endfunction

  //////////////////////////////
  // single left shifter
  assign amt    = shift_en ? shamt : '0;
  assign shl_in = {xlen{shift_en}} & (shift_right ? bit_rev(op1) : op1); // quiet when idle

  assign shl_out = shl_in << amt;

  // right shift = reverse, shift left, reverse back
  assign srl_res = bit_rev(shl_out);

  // upper amt bits are vacated, refill them with the sign
  assign eff_mask = {xlen{1'b1}} >> amt;
  assign sra_res  = (srl_res & eff_mask) | ({xlen{op1[xlen-1]}} & ~eff_mask);

  always_comb begin
    if (!shift_right) begin
      shift_res = shl_out;  // sll
    end else if (shift_arith) begin
      shift_res = sra_res;
    end else begin
      shift_res = srl_res;
    end
  end

endmodule

//--- design/alu_adder.sv
module alu_adder (
  input  logic                 add_en,
  input  logic                 sub_en,
  input  logic                 op_unsigned,
  input  alu_pkg::word_t       op1,
  input  alu_pkg::word_t       op2,
  output alu_pkg::adder_word_t sum
);
  import alu_pkg::*;

  adder_word_t op1_ext;  // sign or zero extended
  adder_word_t op2_ext;
  adder_word_t in1;
  adder_word_t in2;
  logic        addsub;   // adder in use at all
  logic        cin;

  //////////////////////////////
  // extension, one extra bit so the difference never overflows
  assign op1_ext = {~op_unsigned & op1[xlen-1], op1};
  assign op2_ext = {~op_unsigned & op2[xlen-1], op2};

  assign addsub = add_en | sub_en;

  // gate inputs to zero when nobody asked for the adder
  assign in1 = {(xlen+1){addsub}} & op1_ext;
  assign in2 = {(xlen+1){addsub}} & (sub_en ? ~op2_ext : op2_ext); // invert for a - b

  assign cin = addsub & sub_en; // +1 completes two's complement

  // bit xlen ends up set exactly when op1 < op2
  assign sum = in1 + in2 + {{xlen{1'b0}}, cin};

endmodule

//--- design/alu_result.sv
module alu_result (
  input  logic                 cmp_res,     // clock
  input  logic                 rst,
  input  logic                 req,
  input  alu_pkg::res_sel_t    res_sel,
  input  alu_pkg::logic_kind_t logic_kind,
  input  alu_pkg::cmp_kind_t   cmp_kind,
  input  alu_pkg::word_t       op1,
  input  alu_pkg::word_t       op2,
  input  alu_pkg::word_t       shift_res,
  input  alu_pkg::adder_word_t sum,
  output logic                 res_valid,
  output alu_pkg::word_t       res,
  output logic                 cmp_taken
);
  import alu_pkg::*;

  word_t xor_res;
  word_t logic_res;
  word_t slt_res;
  word_t maxmin_res;
  word_t res_nxt;
  logic  neq;          // any differing bit
  logic  op1_lt_op2;   // sign of op1 - op2
  logic  op1_gt_op2;   // inverse of lt, so equal counts as gt
  logic  maxmin_op1;   // pick op1 for max/min
  logic  cmp_nxt;

  //////////////////////////////
  // logic unit, xor doubles as equality check
  assign xor_res = op1 ^ op2;

  always_comb begin
    case (logic_kind)
      lk_or:   logic_res = op1 | op2;
      lk_and:  logic_res = op1 & op2;
      default: logic_res = xor_res;
    endcase
  end

  assign neq        = |xor_res;
  assign op1_lt_op2 = sum[xlen];
  assign op1_gt_op2 = ~op1_lt_op2;

  //////////////////////////////
  // slt and max/min
  assign slt_res = {{(xlen-1){1'b0}}, op1_lt_op2};

  assign maxmin_op1 = ((cmp_kind == ck_maxsel_max) &  op1_gt_op2)
                    | ((cmp_kind == ck_maxsel_min) & ~op1_gt_op2);
  assign maxmin_res = maxmin_op1 ? op1 : op2;

  //////////////////////////////
  // final select
  always_comb begin
    case (res_sel)
      sel_adder:  res_nxt = sum[xlen-1:0]; // drop ext bit
      sel_logic:  res_nxt = logic_res;
      sel_shift:  res_nxt = shift_res;
      sel_slt:    res_nxt = slt_res;
      sel_op2:    res_nxt = op2;           // lui / swap
      sel_maxmin: res_nxt = maxmin_res;
      default:    res_nxt = '0;            // compares give zero
    endcase
  end

  // branch outcome, zero for everything else
  always_comb begin
    case (cmp_kind)
      ck_eq:   cmp_nxt = ~neq;
      ck_ne:   cmp_nxt = neq;
      ck_lt:   cmp_nxt = op1_lt_op2;
      ck_gt:   cmp_nxt = op1_gt_op2;
      default: cmp_nxt = 1'b0;
    endcase
  end

  //////////////////////////////
  // output register, one cycle latency
  always_ff @(posedge cmp_res) begin
    if (rst) begin
      res_valid <= 1'b0;
      res       <= '0;
      cmp_taken <= 1'b0;
    end else begin
      res_valid <= req;     // strobe follows request
      if (req) begin        // hold last result on idle cycles
        res       <= res_nxt;
        cmp_taken <= cmp_nxt;
      end
    end
  end

endmodule

//--- design/alu_dpath.sv
module alu_dpath (
  input  logic             cmp_res,   // clock
  input  logic             rst,
  input  logic             req,       // single-cycle strobe
  input  alu_pkg::alu_op_t op,
  input  alu_pkg::word_t   op1,
  input  alu_pkg::word_t   op2,
  output logic             res_valid, // one cycle after req
  output alu_pkg::word_t   res,
  output logic             cmp_taken
);
  import alu_pkg::*;

  //////////////////////////////
  // decode controls
  logic        shift_en;
  logic        shift_right;
  logic        shift_arith;
  logic        add_en;
  logic        sub_en;
  logic        op_unsigned;
  res_sel_t    res_sel;
  logic_kind_t logic_kind;
  cmp_kind_t   cmp_kind;

  // datapath results
  word_t       shift_res;
  adder_word_t sum;       // msb carries the compare

  alu_decode u_decode (
    .req         (req),
    .op          (op),
    .shift_en    (shift_en),
    .shift_right (shift_right),
    .shift_arith (shift_arith),
    .add_en      (add_en),
    .sub_en      (sub_en),
    .op_unsigned (op_unsigned),
    .res_sel     (res_sel),
    .logic_kind  (logic_kind),
    .cmp_kind    (cmp_kind)
  );

  // shift amount is the low bits of op2
  alu_shifter u_shifter (
    .shift_en    (shift_en),
    .shift_right (shift_right),
    .shift_arith (shift_arith),
    .op1         (op1),
    .shamt       (op2[shamt_w-1:0]),
    .shift_res   (shift_res)
  );

  alu_adder u_adder (
    .add_en      (add_en),
    .sub_en      (sub_en),
    .op_unsigned (op_unsigned),
    .op1         (op1),
    .op2         (op2),
    .sum         (sum)
  );

  //////////////////////////////
  // select and register
  alu_result u_result (
    .cmp_res     (cmp_res),
    .rst         (rst),
    .req         (req),
    .res_sel     (res_sel),
    .logic_kind  (logic_kind),
    .cmp_kind    (cmp_kind),
    .op1         (op1),
    .op2         (op2),
    .shift_res   (shift_res),
    .sum         (sum),
    .res_valid   (res_valid),
    .res         (res),
    .cmp_taken   (cmp_taken)
  );

endmodule

//--- bench/alu_dpath_assert.sv
module alu_dpath_assert (
  input logic             cmp_res,
  input logic             rst,
  input logic             req,
  input alu_pkg::alu_op_t op,
  input alu_pkg::word_t   op1,
  input alu_pkg::word_t   op2,
  input logic             res_valid,
  input alu_pkg::word_t   res,
  input logic             cmp_taken
);
  timeunit 1ns;
  timeprecision 100ps;
  import alu_pkg::*;

  int    n_rst   = 0;  // one counter per assertion
  int    n_valid = 0;
  int    n_res   = 0;
  int    n_cmp   = 0;
  int    n_hold  = 0;
  int    fail_cnt;     // read by the testbench
  word_t last_exp  = '0;  // latest res or cmp_taken mismatch
  word_t last_got  = '0;
  logic  rst_q;
  logic  req_q;
  word_t exp_res_q;    // model of the request one edge back
  logic  exp_cmp_q;

  ////////////////////////////// reference model
  function automatic word_t model_res(input alu_op_t o, input word_t a, input word_t b);
    case (o)
      op_add:   return a + b;  // wraps mod 2^32
      op_sub:   return a - b;
      op_xor:   return a ^ b;
      op_or:    return a | b;
      op_and:   return a & b;
      op_sll:   return a << b[4:0];  // only the low five bits count
      op_srl:   return a >> b[4:0];
      op_sra:   return word_t'($signed(a) >>> b[4:0]);
      op_slt:   return {31'd0, $signed(a) < $signed(b)};
      op_sltu:  return {31'd0, a < b};
      op_mvop2: return b;
      op_max:   return ($signed(a) > $signed(b)) ? a : b;
      op_min:   return ($signed(a) < $signed(b)) ? a : b;
      op_maxu:  return (a > b) ? a : b;
      op_minu:  return (a < b) ? a : b;
      default:  return '0;  // branch compares
    endcase
  endfunction

  // gt is the inverse of lt, so equal operands take it
  function automatic logic model_cmp(input alu_op_t o, input word_t a, input word_t b);
    case (o)
      op_cmp_eq:  return a == b;
      op_cmp_ne:  return a != b;
      op_cmp_lt:  return $signed(a) < $signed(b);
      op_cmp_gt:  return $signed(a) >= $signed(b);
      op_cmp_ltu: return a < b;
      op_cmp_gtu: return a >= b;
      default:    return 1'b0;
    endcase
  endfunction

  always_ff @(posedge cmp_res) begin
    rst_q <= rst;
    if (rst) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
    exp_res_q <= model_res(op, op1, op2);
    exp_cmp_q <= model_cmp(op, op1, op2);
  end

  assign fail_cnt = n_rst + n_valid + n_res + n_cmp + n_hold;

  ////////////////////////////// checks
  a_reset_clear: assert property (@(posedge cmp_res)
    rst_q |-> (!res_valid && res == '0 && !cmp_taken))
  else begin
    $error("outputs not cleared by reset");
    n_rst = n_rst + 1;
  end

  // strobe follows req by exactly one edge
  a_valid: assert property (@(posedge cmp_res) disable iff (rst)
    res_valid == req_q)
  else begin
    $error("res_valid does not follow req by one cycle");
    n_valid = n_valid + 1;
  end

  a_res: assert property (@(posedge cmp_res) disable iff (rst)
    req_q |-> res == exp_res_q)
  else begin
    $error("res differs from the model");
    last_exp = $sampled(exp_res_q);
    last_got = $sampled(res);
    n_res    = n_res + 1;
  end

  a_cmp: assert property (@(posedge cmp_res) disable iff (rst)
    req_q |-> cmp_taken == exp_cmp_q)
  else begin
    $error("cmp_taken differs from the model");
    last_exp = word_t'($sampled(exp_cmp_q));
    last_got = word_t'($sampled(cmp_taken));
    n_cmp    = n_cmp + 1;
  end

  a_hold: assert property (@(posedge cmp_res) disable iff (rst)
    !req_q |-> ($stable(res) && $stable(cmp_taken)))
  else begin
    $error("res or cmp_taken changed on an idle cycle");
    n_hold = n_hold + 1;
  end

endmodule

bind alu_dpath alu_dpath_assert u_chk (
  .cmp_res   (cmp_res),
  .rst       (rst),
  .req       (req),
  .op        (op),
  .op1       (op1),
  .op2       (op2),
  .res_valid (res_valid),
  .res       (res),
  .cmp_taken (cmp_taken)
);

//--- bench/alu_dpath_tb.sv
module alu_dpath_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import alu_pkg::*;

  localparam int wait_limit = 10;  // cycles allowed for res_valid

  logic    cmp_res;
  logic    rst;
  logic    req;
  alu_op_t op;
  word_t   op1;
  word_t   op2;
  logic    res_valid;
  word_t   res;
  logic    cmp_taken;

  integer seed = 32'h3e29;
  string  cur_test;
  int     fails_at_start;
  int     test_timeouts;
  int     tests_run;
  int     tests_failed;
  int     timeouts;

  word_t   corners [4] = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
  alu_op_t mix     [6] = '{op_add, op_sra, op_cmp_lt, op_maxu, op_xor, op_cmp_gtu};
  alu_op_t ord_ops [6] = '{op_slt, op_sltu, op_max, op_min, op_maxu, op_minu};
  alu_op_t cmp_ops [6] = '{op_cmp_eq, op_cmp_ne, op_cmp_lt, op_cmp_gt, op_cmp_ltu, op_cmp_gtu};

  alu_dpath dut (
    .cmp_res   (cmp_res),
    .rst       (rst),
    .req       (req),
    .op        (op),
    .op1       (op1),
    .op2       (op2),
    .res_valid (res_valid),
    .res       (res),
    .cmp_taken (cmp_taken)
  );

  initial begin
    cmp_res = 1'b0;
    forever #10 cmp_res = ~cmp_res;  // 20 ns period
  end

  ////////////////////////////// helpers
  task automatic open_test(input string name);
    cur_test       = name;
    fails_at_start = dut.u_chk.fail_cnt;
    test_timeouts  = 0;
  endtask

  // poll at the falling edge, values are settled there
  task automatic await_result();
    int n;
    n = 0;
    while (!res_valid && n < wait_limit) begin
      @(negedge cmp_res);
      n++;
    end
    if (!res_valid) begin
      $display("%s: res_valid never arrived within %0d cycles", cur_test, wait_limit);
      test_timeouts++;
      timeouts++;
    end
  endtask

  task automatic issue(input alu_op_t o, input word_t a, input word_t b);
    @(negedge cmp_res);
    req = 1'b1;
    op  = o;
    op1 = a;
    op2 = b;
    @(negedge cmp_res);
    req = 1'b0;
    await_result();
  endtask

  task automatic close_test();
    int n;
    @(negedge cmp_res);  // one idle edge, last checks done
    n = dut.u_chk.fail_cnt - fails_at_start;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
      $display("FAILED %s: expected %h, actual %h, %0d assertion failures",
               cur_test, dut.u_chk.last_exp, dut.u_chk.last_got, n);
    end else if (test_timeouts != 0) begin
      tests_failed++;
      $display("%s did not finish, res_valid missing %0d times", cur_test, test_timeouts);
    end else begin
      $display("test %s ok", cur_test);
    end
  endtask

  ////////////////////////////// stimulus
  initial begin
    int    i;
    int    j;
    int    k;
    word_t a;
    word_t b;
    rst          = 1'b1;
    req          = 1'b0;
    op           = op_add;
    op1          = '0;
    op2          = '0;
    tests_run    = 0;
    tests_failed = 0;
    timeouts     = 0;

    // reset clear is checked while rst is high
    open_test("reset_timing");
    repeat (16) @(posedge cmp_res);
    @(negedge cmp_res);
    rst = 1'b0;
    issue(op_add, 32'd5, 32'd7);
    repeat (3) @(negedge cmp_res);  // idle, strobe low, outputs hold
    for (i = 0; i < 6; i++) begin   // back to back
      @(negedge cmp_res);
      req = 1'b1;
      op  = mix[i];
      op1 = $random(seed);
      op2 = $random(seed);
    end
    @(negedge cmp_res);
    req = 1'b0;
    await_result();
    close_test();

    open_test("add_sub");
    for (i = 0; i < 4; i++) begin
      for (k = 0; k < 4; k++) begin
        issue(op_add, corners[i], corners[k]);
        issue(op_sub, corners[i], corners[k]);
      end
    end
    for (i = 0; i < 16; i++) begin
      issue(op_add, $random(seed), $random(seed));
      issue(op_sub, $random(seed), $random(seed));
    end
    close_test();

    open_test("shifts");
    for (i = 0; i < 6; i++) begin
      a     = $random(seed);
      a[31] = i[0];  // both sign fills
      for (k = 0; k < 4; k++) begin
        b = $random(seed);  // upper bits must not matter
        if (k == 0) begin
          b[4:0] = 5'd0;
        end else if (k == 1) begin
          b[4:0] = 5'd1;
        end else if (k == 2) begin
          b[4:0] = 5'd31;
        end
        issue(op_sll, a, b);
        issue(op_srl, a, b);
        issue(op_sra, a, b);
      end
    end
    close_test();

    open_test("logic_mvop2");
    for (i = 0; i < 12; i++) begin
      issue(op_xor, $random(seed), $random(seed));
      issue(op_or, $random(seed), $random(seed));
      issue(op_and, $random(seed), $random(seed));
      issue(op_mvop2, $random(seed), $random(seed));
    end
    close_test();

    // corners make signed and unsigned orders disagree
    open_test("slt_maxmin");
    for (j = 0; j < 6; j++) begin
      for (i = 0; i < 4; i++) begin
        for (k = 0; k < 4; k++) begin
          issue(ord_ops[j], corners[i], corners[k]);
        end
      end
      for (i = 0; i < 8; i++) begin
        issue(ord_ops[j], $random(seed), $random(seed));
      end
    end
    close_test();

    open_test("compares");
    for (j = 0; j < 6; j++) begin
      a = $random(seed);
      issue(cmp_ops[j], a, a);  // equal operands
      for (i = 0; i < 4; i++) begin
        for (k = 0; k < 4; k++) begin
          issue(cmp_ops[j], corners[i], corners[k]);
        end
      end
      for (i = 0; i < 8; i++) begin
        issue(cmp_ops[j], $random(seed), $random(seed));
      end
    end
    close_test();

    $display("tests run %0d, failed %0d, assertion failures %0d, timeouts %0d",
             tests_run, tests_failed, dut.u_chk.fail_cnt, timeouts);
    if (tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- compile.f
design/alu_pkg.sv
design/alu_decode.sv
design/alu_shifter.sv
design/alu_adder.sv
design/alu_result.sv
design/alu_dpath.sv
bench/alu_dpath_assert.sv
bench/alu_dpath_tb.sv

//--- run.sh
#!/bin/sh
# build and run the alu_dpath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module alu_dpath_tb -o sim_alu

# keep going past assertion errors so the summary line is printed
./obj_dir/sim_alu +verilator+error+limit+1000 | tee /dev/stderr | grep -q "All checks passed"
